// ==== rtl/periph_pkg.sv ====
package periph_pkg;

  // bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int GPIO_W = 8;

  // address bits that pick a peripheral slot
  localparam int SLOT_MSB = 15;
  localparam int SLOT_LSB = 12;

  // slot 0 is gpio; 1 (old spi), 2 (old uart) and up are unmapped
  localparam logic [SLOT_MSB-SLOT_LSB:0] SLOT_GPIO = 4'd0;

  // gpio register offsets within the slot
  localparam logic [SLOT_LSB-1:0] REG_DATA_OUT   = 12'h000;
  localparam logic [SLOT_LSB-1:0] REG_OUT_EN     = 12'h004;
  localparam logic [SLOT_LSB-1:0] REG_DATA_IN    = 12'h008;
  localparam logic [SLOT_LSB-1:0] REG_IRQ_MASK   = 12'h00C;
  localparam logic [SLOT_LSB-1:0] REG_IRQ_STATUS = 12'h010;

  // axi response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // slave stage FSM states
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_ISSUE = 2'd1;
  localparam logic [1:0] ST_WAIT  = 2'd2;
  localparam logic [1:0] ST_RESP  = 2'd3;

endpackage

// ==== rtl/axil_slave_stage.sv ====
`timescale 1ns/1ps

module axil_slave_stage (
  input  logic                          dev_clk,
  input  logic                          rst_n,
  input  logic                          awvalid_i,
  output logic                          awready_o,
  input  logic [periph_pkg::ADDR_W-1:0] awaddr_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,
  input  logic [periph_pkg::DATA_W-1:0] wdata_i,
  input  logic [periph_pkg::STRB_W-1:0] wstrb_i,
  output logic                          bvalid_o,
  input  logic                          bready_i,
  output logic [1:0]                    bresp_o,
  input  logic                          arvalid_i,
  output logic                          arready_o,
  input  logic [periph_pkg::ADDR_W-1:0] araddr_i,
  output logic                          rvalid_o,
  input  logic                          rready_i,
  output logic [periph_pkg::DATA_W-1:0] rdata_o,
  output logic [1:0]                    rresp_o,
  output logic                          req_valid_o,
  input  logic                          req_ready_i,
  output logic                          req_write_o,
  output logic [periph_pkg::ADDR_W-1:0] req_addr_o,
  output logic [periph_pkg::DATA_W-1:0] req_wdata_o,
  output logic [periph_pkg::STRB_W-1:0] req_strb_o,
  input  logic                          rsp_valid_i,
  input  logic [periph_pkg::DATA_W-1:0] rsp_rdata_i,
  input  logic                          rsp_err_i
);
  import periph_pkg::*;

  logic [1:0]        state_q;
  logic              run_q;
  logic              aw_held_q;
  logic              w_held_q;
  logic              wr_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [STRB_W-1:0] strb_q;
  logic [DATA_W-1:0] rdata_q;
  logic [1:0]        resp_q;

  logic idle;
  logic rd_first;
  logic aw_fire;
  logic w_fire;
  logic ar_fire;
  logic wr_ready;
  logic rsp_done;

  // ports stay closed until the first edge after reset
  assign idle = run_q && (state_q == ST_IDLE);

  // a read only goes first when no write half is captured yet
  assign rd_first = arvalid_i && !aw_held_q && !w_held_q;

  assign arready_o = idle && !aw_held_q && !w_held_q;
  assign awready_o = idle && !aw_held_q && !rd_first;
  assign wready_o  = idle && !w_held_q && !rd_first;

  assign aw_fire = awvalid_i && awready_o;
  assign w_fire  = wvalid_i && wready_o;
  assign ar_fire = arvalid_i && arready_o;

  assign wr_ready = (aw_held_q || aw_fire) && (w_held_q || w_fire);
  assign rsp_done = wr_q ? bready_i : rready_i;

  always_ff @(posedge dev_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= ST_IDLE;
      run_q     <= 1'b0;
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
      wr_q      <= 1'b0;
    end else begin
      run_q <= 1'b1;
      case (state_q)
        ST_IDLE: begin
          if (ar_fire) begin
            wr_q    <= 1'b0;
            state_q <= ST_ISSUE;
          end else if (wr_ready) begin
            aw_held_q <= 1'b0;
            w_held_q  <= 1'b0;
            wr_q      <= 1'b1;
            state_q   <= ST_ISSUE;
          end else begin
            aw_held_q <= aw_held_q || aw_fire;
            w_held_q  <= w_held_q || w_fire;
          end
        end
        ST_ISSUE: begin
          if (req_ready_i) begin
            state_q <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (rsp_valid_i) begin
            state_q <= ST_RESP;
          end
        end
        default: begin
          // hold the response until the master takes it
          if (rsp_done) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge dev_clk) begin
    if (aw_fire) begin
      addr_q <= awaddr_i;
    end
    if (ar_fire) begin
      addr_q <= araddr_i;
    end
    if (w_fire) begin
      wdata_q <= wdata_i;
      strb_q  <= wstrb_i;
    end
    if (state_q == ST_WAIT && rsp_valid_i) begin
      rdata_q <= rsp_rdata_i;
      resp_q  <= rsp_err_i ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign req_valid_o = (state_q == ST_ISSUE);
  assign req_write_o = wr_q;
  assign req_addr_o  = addr_q;
  assign req_wdata_o = wdata_q;
  assign req_strb_o  = strb_q;

  assign bvalid_o = (state_q == ST_RESP) && wr_q;
  assign bresp_o  = resp_q;
  assign rvalid_o = (state_q == ST_RESP) && !wr_q;
  assign rdata_o  = rdata_q;
  assign rresp_o  = resp_q;

endmodule

// ==== rtl/slot_decoder.sv ====
`timescale 1ns/1ps

module slot_decoder (
  input  logic                            dev_clk,
  input  logic                            rst_n,
  input  logic                            req_valid_i,
  output logic                            req_ready_o,
  input  logic                            req_write_i,
  input  logic [periph_pkg::ADDR_W-1:0]   req_addr_i,
  input  logic [periph_pkg::DATA_W-1:0]   req_wdata_i,
  input  logic [periph_pkg::STRB_W-1:0]   req_strb_i,
  output logic                            greq_valid_o,
  output logic                            greq_write_o,
  output logic [periph_pkg::SLOT_LSB-1:0] greq_offset_o,
  output logic [periph_pkg::DATA_W-1:0]   greq_wdata_o,
  output logic [periph_pkg::STRB_W-1:0]   greq_strb_o,
  input  logic                            gpio_rsp_valid_i,
  input  logic [periph_pkg::DATA_W-1:0]   gpio_rsp_rdata_i,
  input  logic                            gpio_rsp_err_i,
  output logic                            rsp_valid_o,
  output logic [periph_pkg::DATA_W-1:0]   rsp_rdata_o,
  output logic                            rsp_err_o
);
  import periph_pkg::*;

  logic gpio_hit;
  logic miss_q;
  logic err_valid_q;

  // gpio never stalls, so neither does the decoder
  assign req_ready_o = 1'b1;

  assign gpio_hit = (req_addr_i[SLOT_MSB:SLOT_LSB] == SLOT_GPIO);

  always_ff @(posedge dev_clk or negedge rst_n) begin
    if (!rst_n) begin
      greq_valid_o <= 1'b0;
      miss_q       <= 1'b0;
      err_valid_q  <= 1'b0;
    end else begin
      greq_valid_o <= req_valid_i && gpio_hit;
      miss_q       <= req_valid_i && !gpio_hit;
      // unmapped slot answers one cycle later, same as gpio
      err_valid_q  <= miss_q;
    end
  end

  always_ff @(posedge dev_clk) begin
    if (req_valid_i) begin
      greq_write_o  <= req_write_i;
      greq_offset_o <= req_addr_i[SLOT_LSB-1:0];
      greq_wdata_o  <= req_wdata_i;
      greq_strb_o   <= req_strb_i;
    end
  end

  // merge own error with gpio response
  assign rsp_valid_o = gpio_rsp_valid_i || err_valid_q;
  assign rsp_rdata_o = err_valid_q ? '0 : gpio_rsp_rdata_i;
  assign rsp_err_o   = err_valid_q || gpio_rsp_err_i;

endmodule

// ==== rtl/gpio_regs.sv ====
`timescale 1ns/1ps

module gpio_regs (
  input  logic                            dev_clk,
  input  logic                            rst_n,
  input  logic                            greq_valid_i,
  input  logic                            greq_write_i,
  input  logic [periph_pkg::SLOT_LSB-1:0] greq_offset_i,
  input  logic [periph_pkg::DATA_W-1:0]   greq_wdata_i,
  input  logic [periph_pkg::STRB_W-1:0]   greq_strb_i,
  input  logic [periph_pkg::GPIO_W-1:0]   gpio_i,
  output logic                            rsp_valid_o,
  output logic [periph_pkg::DATA_W-1:0]   rsp_rdata_o,
  output logic                            rsp_err_o,
  output logic [periph_pkg::GPIO_W-1:0]   gpio_o,
  output logic [periph_pkg::GPIO_W-1:0]   gpio_oe_o,
  output logic                            irq_o
);
  import periph_pkg::*;

  logic [GPIO_W-1:0] data_out_q;
  logic [GPIO_W-1:0] out_en_q;
  logic [GPIO_W-1:0] irq_mask_q;
  logic [GPIO_W-1:0] irq_status_q;
  logic [GPIO_W-1:0] sync1_q;
  logic [GPIO_W-1:0] sync2_q;
  logic [GPIO_W-1:0] prev_q;

  logic [GPIO_W-1:0] bit_en;
  logic [GPIO_W-1:0] wbits;
  logic [GPIO_W-1:0] rise;
  logic [GPIO_W-1:0] status_clr;
  logic              wr_en;
  logic              sel_data_out;
  logic              sel_out_en;
  logic              sel_mask;
  logic              sel_status;
  logic [DATA_W-1:0] rd_data;
  logic              rd_err;

  // byte strobe spread over the pin bits
  always_comb begin
    for (int i = 0; i < GPIO_W; i++) begin
      bit_en[i] = greq_strb_i[i/8];
    end
  end

  assign wbits = greq_wdata_i[GPIO_W-1:0];
  assign wr_en = greq_valid_i && greq_write_i;

  always_comb begin
    sel_data_out = 1'b0;
    sel_out_en   = 1'b0;
    sel_mask     = 1'b0;
    sel_status   = 1'b0;
    rd_data      = '0;
    rd_err       = 1'b0;
    case (greq_offset_i)
      REG_DATA_OUT: begin
        sel_data_out           = 1'b1;
        rd_data[GPIO_W-1:0] = data_out_q;
      end
      REG_OUT_EN: begin
        sel_out_en             = 1'b1;
        rd_data[GPIO_W-1:0] = out_en_q;
      end
      REG_DATA_IN: begin
        rd_data[GPIO_W-1:0] = sync2_q;
      end
      REG_IRQ_MASK: begin
        sel_mask               = 1'b1;
        rd_data[GPIO_W-1:0] = irq_mask_q;
      end
      REG_IRQ_STATUS: begin
        sel_status             = 1'b1;
        rd_data[GPIO_W-1:0] = irq_status_q;
      end
      default: begin
        rd_err = 1'b1;
      end
    endcase
  end

  // rising edge of the synchronised input
  assign rise = sync2_q & ~prev_q;

  // write one to clear
  assign status_clr = (wr_en && sel_status) ? (wbits & bit_en) : '0;

  always_ff @(posedge dev_clk or negedge rst_n) begin
    if (!rst_n) begin
      data_out_q   <= '0;
      out_en_q     <= '0;
      irq_mask_q   <= '0;
      irq_status_q <= '0;
      sync1_q      <= '0;
      sync2_q      <= '0;
      prev_q       <= '0;
      rsp_valid_o  <= 1'b0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr_en && sel_data_out) begin
        data_out_q <= (data_out_q & ~bit_en) | (wbits & bit_en);
      end
      if (wr_en && sel_out_en) begin
        out_en_q <= (out_en_q & ~bit_en) | (wbits & bit_en);
      end
      if (wr_en && sel_mask) begin
        irq_mask_q <= (irq_mask_q & ~bit_en) | (wbits & bit_en);
      end
      // a new edge wins over a clear in the same cycle
      irq_status_q <= (irq_status_q & ~status_clr) | rise;
      rsp_valid_o  <= greq_valid_i;
    end
  end

  always_ff @(posedge dev_clk) begin
    if (greq_valid_i) begin
      rsp_rdata_o <= rd_data;
      rsp_err_o   <= rd_err;
    end
  end

  assign gpio_o    = data_out_q;
  assign gpio_oe_o = out_en_q;
  assign irq_o     = |(irq_status_q & irq_mask_q);

endmodule

// ==== rtl/periph_top.sv ====
`timescale 1ns/1ps

module periph_top (
  input  logic                          dev_clk,
  input  logic                          rst_n,
  input  logic                          awvalid_i,
  output logic                          awready_o,
  input  logic [periph_pkg::ADDR_W-1:0] awaddr_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,
  input  logic [periph_pkg::DATA_W-1:0] wdata_i,
  input  logic [periph_pkg::STRB_W-1:0] wstrb_i,
  output logic                          bvalid_o,
  input  logic                          bready_i,
  output logic [1:0]                    bresp_o,
  input  logic                          arvalid_i,
  output logic                          arready_o,
  input  logic [periph_pkg::ADDR_W-1:0] araddr_i,
  output logic                          rvalid_o,
  input  logic                          rready_i,
  output logic [periph_pkg::DATA_W-1:0] rdata_o,
  output logic [1:0]                    rresp_o,
  input  logic [periph_pkg::GPIO_W-1:0] gpio_i,
  output logic [periph_pkg::GPIO_W-1:0] gpio_o,
  output logic [periph_pkg::GPIO_W-1:0] gpio_oe_o,
  output logic                          irq_o
);
  import periph_pkg::*;

  // request link
  logic              req_valid;
  logic              req_ready;
  logic              req_write;
  logic [ADDR_W-1:0] req_addr;
  logic [DATA_W-1:0] req_wdata;
  logic [STRB_W-1:0] req_strb;

  // decoded gpio link
  logic                greq_valid;
  logic                greq_write;
  logic [SLOT_LSB-1:0] greq_offset;
  logic [DATA_W-1:0]   greq_wdata;
  logic [STRB_W-1:0]   greq_strb;

  logic              gpio_rsp_valid;
  logic [DATA_W-1:0] gpio_rsp_rdata;
  logic              gpio_rsp_err;

  // merged response link
  logic              rsp_valid;
  logic [DATA_W-1:0] rsp_rdata;
  logic              rsp_err;

  axil_slave_stage u_axil_slave_stage (
    .dev_clk     (dev_clk),
    .rst_n       (rst_n),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .awaddr_i    (awaddr_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .wdata_i     (wdata_i),
    .wstrb_i     (wstrb_i),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i),
    .bresp_o     (bresp_o),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .araddr_i    (araddr_i),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .rdata_o     (rdata_o),
    .rresp_o     (rresp_o),
    .req_valid_o (req_valid),
    .req_ready_i (req_ready),
    .req_write_o (req_write),
    .req_addr_o  (req_addr),
    .req_wdata_o (req_wdata),
    .req_strb_o  (req_strb),
    .rsp_valid_i (rsp_valid),
    .rsp_rdata_i (rsp_rdata),
    .rsp_err_i   (rsp_err)
  );

  slot_decoder u_slot_decoder (
    .dev_clk          (dev_clk),
    .rst_n            (rst_n),
    .req_valid_i      (req_valid),
    .req_ready_o      (req_ready),
    .req_write_i      (req_write),
    .req_addr_i       (req_addr),
    .req_wdata_i      (req_wdata),
    .req_strb_i       (req_strb),
    .greq_valid_o     (greq_valid),
    .greq_write_o     (greq_write),
    .greq_offset_o    (greq_offset),
    .greq_wdata_o     (greq_wdata),
    .greq_strb_o      (greq_strb),
    .gpio_rsp_valid_i (gpio_rsp_valid),
    .gpio_rsp_rdata_i (gpio_rsp_rdata),
    .gpio_rsp_err_i   (gpio_rsp_err),
    .rsp_valid_o      (rsp_valid),
    .rsp_rdata_o      (rsp_rdata),
    .rsp_err_o        (rsp_err)
  );

  gpio_regs u_gpio_regs (
    .dev_clk       (dev_clk),
    .rst_n         (rst_n),
    .greq_valid_i  (greq_valid),
    .greq_write_i  (greq_write),
    .greq_offset_i (greq_offset),
    .greq_wdata_i  (greq_wdata),
    .greq_strb_i   (greq_strb),
    .gpio_i        (gpio_i),
    .rsp_valid_o   (gpio_rsp_valid),
    .rsp_rdata_o   (gpio_rsp_rdata),
    .rsp_err_o     (gpio_rsp_err),
    .gpio_o        (gpio_o),
    .gpio_oe_o     (gpio_oe_o),
    .irq_o         (irq_o)
  );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic dev_clk_o
);

  // 20 ns period
  initial begin
    dev_clk_o = 1'b0;
    forever begin
      #10 dev_clk_o = ~dev_clk_o;
    end
  end

endmodule

// ==== verification/tb_scoreboard.sv ====
`timescale 1ns/1ps

module tb_scoreboard (
  input  logic        dev_clk,
  input  logic        rst_n,
  input  logic        bvalid_i,
  input  logic        bready_i,
  input  logic [1:0]  bresp_i,
  input  logic        rvalid_i,
  input  logic        rready_i,
  input  logic [31:0] rdata_i,
  input  logic [1:0]  rresp_i,
  input  logic [7:0]  gpio_out_i,
  input  logic [7:0]  gpio_oe_i,
  input  logic        irq_i,
  input  int          case_idx_i,
  input  logic        case_done_i,
  output int          resp_errs_o,
  output int          data_errs_o,
  output int          pin_errs_o,
  output int          pin_checks_o
);

  localparam int N_FIELDS = 11;
  localparam int MAX_ROWS = 64;

  logic [31:0] case_mem [0:N_FIELDS*MAX_ROWS-1];

  function automatic logic [31:0] field(input int row, input int col);
    return case_mem[row * N_FIELDS + col];
  endfunction

  function automatic int mismatch(input string name, input logic [31:0] exp_val,
                                  input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp_val, act_val);
      return 1;
    end
    return 0;
  endfunction

  initial begin
    resp_errs_o  = 0;
    data_errs_o  = 0;
    pin_errs_o   = 0;
    pin_checks_o = 0;
    $readmemh("verification/periph_cases.txt", case_mem);
  end

  always @(posedge dev_clk) begin
    if (rst_n) begin
      if (bvalid_i && bready_i) begin
        resp_errs_o = resp_errs_o + mismatch("bresp", field(case_idx_i, 7), {30'b0, bresp_i});
      end
      if (rvalid_i && rready_i) begin
        resp_errs_o = resp_errs_o + mismatch("rresp", field(case_idx_i, 7), {30'b0, rresp_i});
        data_errs_o = data_errs_o + mismatch("rdata", field(case_idx_i, 6), rdata_i);
      end
      // pins settle before the case is marked done
      if (case_done_i) begin
        pin_checks_o = pin_checks_o + 1;
        pin_errs_o = pin_errs_o + mismatch("gpio_o", field(case_idx_i, 8), {24'b0, gpio_out_i});
        pin_errs_o = pin_errs_o + mismatch("gpio_oe_o", field(case_idx_i, 9), {24'b0, gpio_oe_i});
        pin_errs_o = pin_errs_o + mismatch("irq_o", field(case_idx_i, 10), {31'b0, irq_i});
      end
    end
  end

endmodule

// ==== verification/periph_protocol_checker.sv ====
`timescale 1ns/1ps

module periph_protocol_checker (
  input logic        dev_clk,
  input logic        rst_n,
  input logic        awready_i,
  input logic        wready_i,
  input logic        arready_i,
  input logic        bvalid_i,
  input logic        bready_i,
  input logic [1:0]  bresp_i,
  input logic        rvalid_i,
  input logic        rready_i,
  input logic [31:0] rdata_i,
  input logic [1:0]  rresp_i,
  input logic        irq_i
);

  int assert_fails = 0;

  // write response held while bready is low
  b_hold: assert property (@(posedge dev_clk) disable iff (!rst_n)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else begin
      assert_fails = assert_fails + 1;
      $error("write response dropped or changed while bready was low");
    end

  // read response held while rready is low
  r_hold: assert property (@(posedge dev_clk) disable iff (!rst_n)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
    else begin
      assert_fails = assert_fails + 1;
      $error("read response dropped or changed while rready was low");
    end

  // bus ports closed and quiet in reset
  reset_quiet: assert property (@(posedge dev_clk)
    !rst_n |-> !bvalid_i && !rvalid_i && !irq_i && !awready_i && !wready_i && !arready_i)
    else begin
      assert_fails = assert_fails + 1;
      $error("response valid, address or data ready, or irq high during reset");
    end

endmodule

bind periph_top periph_protocol_checker u_protocol_checker (
  .dev_clk   (dev_clk),
  .rst_n     (rst_n),
  .awready_i (awready_o),
  .wready_i  (wready_o),
  .arready_i (arready_o),
  .bvalid_i  (bvalid_o),
  .bready_i  (bready_i),
  .bresp_i   (bresp_o),
  .rvalid_i  (rvalid_o),
  .rready_i  (rready_i),
  .rdata_i   (rdata_o),
  .rresp_i   (rresp_o),
  .irq_i     (irq_o)
);

// ==== verification/tb_periph_top.sv ====
`timescale 1ns/1ps

module tb_periph_top;
  import periph_pkg::*;

  localparam int N_FIELDS = 11;
  localparam int MAX_ROWS = 64;

  logic              dev_clk;
  logic              rst_n;
  logic              awvalid;
  logic              awready;
  logic [ADDR_W-1:0] awaddr;
  logic              wvalid;
  logic              wready;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              bvalid;
  logic              bready;
  logic [1:0]        bresp;
  logic              arvalid;
  logic              arready;
  logic [ADDR_W-1:0] araddr;
  logic              rvalid;
  logic              rready;
  logic [DATA_W-1:0] rdata;
  logic [1:0]        rresp;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_oe;
  logic              irq;

  int          case_idx;
  logic        case_done;
  int          resp_errs;
  int          data_errs;
  int          pin_errs;
  int          pin_checks;
  int          n_cases;
  int          limit;
  int          cycle_count;
  int          delay;
  int          total_errs;
  int unsigned lcg_state;
  logic [31:0] op;
  logic [31:0] case_mem [0:N_FIELDS*MAX_ROWS-1];

  tb_clock_gen u_clock_gen (
    .dev_clk_o (dev_clk)
  );

  periph_top uut (
    .dev_clk   (dev_clk),
    .rst_n     (rst_n),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .awaddr_i  (awaddr),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .wdata_i   (wdata),
    .wstrb_i   (wstrb),
    .bvalid_o  (bvalid),
    .bready_i  (bready),
    .bresp_o   (bresp),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .araddr_i  (araddr),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .rdata_o   (rdata),
    .rresp_o   (rresp),
    .gpio_i    (gpio_in),
    .gpio_o    (gpio_out),
    .gpio_oe_o (gpio_oe),
    .irq_o     (irq)
  );

  tb_scoreboard u_scoreboard (
    .dev_clk      (dev_clk),
    .rst_n        (rst_n),
    .bvalid_i     (bvalid),
    .bready_i     (bready),
    .bresp_i      (bresp),
    .rvalid_i     (rvalid),
    .rready_i     (rready),
    .rdata_i      (rdata),
    .rresp_i      (rresp),
    .gpio_out_i   (gpio_out),
    .gpio_oe_i    (gpio_oe),
    .irq_i        (irq),
    .case_idx_i   (case_idx),
    .case_done_i  (case_done),
    .resp_errs_o  (resp_errs),
    .data_errs_o  (data_errs),
    .pin_errs_o   (pin_errs),
    .pin_checks_o (pin_checks)
  );

  function automatic logic [31:0] field(input int row, input int col);
    return case_mem[row * N_FIELDS + col];
  endfunction

  function automatic int unsigned lcg_next(input int unsigned state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // rows end at the first op that is not write, read or set-input
  function automatic int count_rows();
    int n;
    n = 0;
    while (n < MAX_ROWS && (field(n, 0) === 1 || field(n, 0) === 2 || field(n, 0) === 3)) begin
      n++;
    end
    return n;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge dev_clk);
    #2;
  endtask

  task automatic finish_case();
    case_done = 1'b1;
    wait_cycles(1);
    case_done = 1'b0;
  endtask

  task automatic take_response(input int ready_delay, input logic is_write);
    @(posedge dev_clk);
    while (!(is_write ? bvalid : rvalid)) begin
      @(posedge dev_clk);
    end
    wait_cycles(ready_delay);
    if (is_write) begin
      bready = 1'b1;
    end else begin
      rready = 1'b1;
    end
    // handshake edge
    wait_cycles(1);
    bready = 1'b0;
    rready = 1'b0;
    finish_case();
  endtask

  task automatic run_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb, input int ready_delay);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = strb;
    while (awvalid || wvalid) begin
      @(posedge dev_clk);
      if (awready) begin
        awvalid <= #2 1'b0;
      end
      if (wready) begin
        wvalid <= #2 1'b0;
      end
      #2;
    end
    take_response(ready_delay, 1'b1);
  endtask

  task automatic run_read(input logic [ADDR_W-1:0] addr, input int ready_delay);
    arvalid = 1'b1;
    araddr  = addr;
    while (arvalid) begin
      @(posedge dev_clk);
      if (arready) begin
        arvalid <= #2 1'b0;
      end
      #2;
    end
    take_response(ready_delay, 1'b0);
  endtask

  task automatic print_counts();
    $display("error counts: response=%0d read_data=%0d pins=%0d assertions=%0d",
             resp_errs, data_errs, pin_errs, uut.u_protocol_checker.assert_fails);
  endtask

  always @(posedge dev_clk) begin
    cycle_count = cycle_count + 1;
    if (limit > 0 && cycle_count >= limit) begin
      $display("timeout: cases did not complete within %0d cycles", limit);
      print_counts();
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    rst_n       = 1'b0;
    awvalid     = 1'b0;
    awaddr      = '0;
    wvalid      = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    bready      = 1'b0;
    arvalid     = 1'b0;
    araddr      = '0;
    rready      = 1'b0;
    gpio_in     = '0;
    case_idx    = 0;
    case_done   = 1'b0;
    cycle_count = 0;
    lcg_state   = 52;
    $readmemh("verification/periph_cases.txt", case_mem);
    n_cases = count_rows();
    limit   = n_cases * 40 + 200;
    wait_cycles(10);
    rst_n = 1'b1;
    wait_cycles(2);
    for (int row = 0; row < n_cases; row++) begin
      case_idx = row;
      op       = field(row, 0);
      delay    = field(row, 5);
      // ff marks a random bready/rready delay
      if (delay == 'hff) begin
        lcg_state = lcg_next(lcg_state);
        delay     = ((lcg_state >> 16) % 6) + 1;
      end
      case (op)
        1: run_write(ADDR_W'(field(row, 1)), field(row, 2), STRB_W'(field(row, 3)), delay);
        2: run_read(ADDR_W'(field(row, 1)), delay);
        default: begin
          gpio_in = GPIO_W'(field(row, 4));
          wait_cycles(4);
          finish_case();
        end
      endcase
    end
    wait_cycles(2);
    total_errs = resp_errs + data_errs + pin_errs + uut.u_protocol_checker.assert_fails;
    if (n_cases == 0 || pin_checks != n_cases) begin
      $display("only %0d of %0d cases reached their output check", pin_checks, n_cases);
      total_errs = total_errs + 1;
    end
    print_counts();
    if (total_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
rtl/periph_pkg.sv
rtl/axil_slave_stage.sv
rtl/slot_decoder.sv
rtl/gpio_regs.sv
rtl/periph_top.sv
verification/tb_clock_gen.sv
verification/tb_scoreboard.sv
verification/periph_protocol_checker.sv
verification/tb_periph_top.sv

// ==== Bender.yml ====
package:
  name: periph_pipeline

sources:
  - rtl/periph_pkg.sv
  - rtl/axil_slave_stage.sv
  - rtl/slot_decoder.sv
  - rtl/gpio_regs.sv
  - rtl/periph_top.sv
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_scoreboard.sv
      - verification/periph_protocol_checker.sv
      - verification/tb_periph_top.sv

// ==== verification/periph_cases.txt ====
// op addr data strb gpio_in ready_delay exp_rdata exp_resp exp_gpio_o exp_gpio_oe exp_irq
// op 1=write 2=read 3=set gpio_in; delay ff=random; all hex
1 0000 000000a5 f 00 00 00000000 0 a5 00 0
2 0000 00000000 0 00 00 000000a5 0 a5 00 0
1 0000 ffffff5a 1 00 02 00000000 0 5a 00 0
1 0000 000000c3 e 00 00 00000000 0 5a 00 0
2 0000 00000000 0 00 ff 0000005a 0 5a 00 0
1 0004 000000f0 f 00 00 00000000 0 5a f0 0
2 0004 00000000 0 00 01 000000f0 0 5a f0 0
1 000c 00000001 f 00 00 00000000 0 5a f0 0
3 0000 00000000 0 03 00 00000000 0 5a f0 1
2 0008 00000000 0 03 00 00000003 0 5a f0 1
2 0010 00000000 0 03 03 00000003 0 5a f0 1
1 0010 00000001 f 03 ff 00000000 0 5a f0 0
2 0010 00000000 0 03 00 00000002 0 5a f0 0
3 0000 00000000 0 00 00 00000000 0 5a f0 0
3 0000 00000000 0 04 00 00000000 0 5a f0 0
1 000c 00000004 f 04 00 00000000 0 5a f0 1
1 0010 00000006 f 04 00 00000000 0 5a f0 0
1 1000 deadbeef f 04 04 00000000 2 5a f0 0
2 2000 00000000 0 04 00 00000000 2 5a f0 0
2 0014 00000000 0 04 ff 00000000 2 5a f0 0
1 0014 000000ff f 04 00 00000000 2 5a f0 0
2 0000 00000000 0 04 05 0000005a 0 5a f0 0
2 0004 00000000 0 04 ff 000000f0 0 5a f0 0
2 000c 00000000 0 04 00 00000004 0 5a f0 0
